// ==== files.f ====
hw/uart_rx_pkg.sv
hw/uart_rx.sv
hw/rx_fifo.sv
hw/wb_rx_port.sv
hw/uart_rx_top.sv
sim/uart_rx_checker.sv
sim/uart_rx_scoreboard.sv
sim/tb_uart_rx.sv

// ==== hw/rx_fifo.sv ====
`timescale 1ns/1ps

module rx_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     Clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int AW = $clog2(DEPTH);  // DEPTH is a power of two

    // Circular buffer storage
    payload_t mem [DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;   // A push into a full buffer is lost
    assign do_pop  = pop && !empty;   // Popping an empty buffer does nothing

    // Same address, same lap means nothing stored
    assign empty = (wr_ptr == rd_ptr);

    // Same address, different lap means every slot is taken
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Oldest entry is always on the output without read latency
    assign head = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge Clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    // Push and pop in one clock both move their pointer
    always_ff @(posedge Clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int DATA_BITS = 8,
    parameter int STOP_BITS = 2,
    parameter int CLK_DIV   = 2
) (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  rxd,
    input  logic                  full,
    output logic                  rts,
    output logic                  push,
    output uart_rx_pkg::rx_char_t push_char,
    output logic                  overrun_pulse
);

    // Start, data, parity and stop bits in one frame
    localparam int NUM_BITS = 1 + DATA_BITS + 1 + STOP_BITS;
    localparam int DIV_W    = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int CNT_W    = $clog2(NUM_BITS);
    localparam int PAR_POS  = DATA_BITS + 1;  // Parity bit position in the shift register

    typedef enum logic [1:0] {
        ST_IDLE,     // Waiting for a falling edge on the line
        ST_RECV,     // Sampling the frame
        ST_CHECK,    // Computing the error flags
        ST_DELIVER   // Pushing the character or flagging overrun
    } state_t;

    state_t state;

    // Oversampling counters
    logic [DIV_W-1:0] div_cnt;     // Clocks within one oversample tick
    logic [3:0]       sample_cnt;  // Ticks within one bit, wraps every 16
    logic [CNT_W-1:0] bit_cnt;     // Bits sampled so far in this frame
    logic             tick;
    logic             sample;
    logic             last_bit;

    // Frame bits with the first bit on the line ending up in bit 0
    logic [NUM_BITS-1:0] shreg;

    // Fields pulled out of the finished frame
    logic [DATA_BITS-1:0]                 data_bits;
    logic [uart_rx_pkg::MAX_DATA_BITS-1:0] data_ext;
    logic                                 parity_bit;
    logic [STOP_BITS-1:0]                 stop_bits;

    uart_rx_pkg::rx_char_t char_q;

    // One tick every CLK_DIV clocks while a frame is being received
    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    // The eighth tick of a bit period lands in the middle of the bit
    assign sample = tick && (sample_cnt == 4'd7);

    assign last_bit = (bit_cnt == CNT_W'(NUM_BITS - 1));  // The final stop bit

    // State register and counters
    always_ff @(posedge Clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            div_cnt    <= '0;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!rxd) begin
                        state <= ST_RECV;  // Falling edge starts the tick count from zero
                    end
                end
                ST_RECV: begin
                    if (sample && last_bit) begin
                        state <= ST_CHECK;  // All bits are in once the last stop bit is taken
                    end
                end
                ST_CHECK: begin
                    state <= ST_DELIVER;
                end
                default: begin
                    state <= ST_IDLE;  // Back to idle right after delivery
                end
            endcase

            // Counters only run inside a frame and sit at zero otherwise
            if (state == ST_RECV) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    sample_cnt <= sample_cnt + 1'b1;  // Wraps naturally after 16 ticks
                end
                if (sample) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                div_cnt    <= '0;
                sample_cnt <= '0;
                bit_cnt    <= '0;
            end
        end
    end

    // Each bit enters at the top and moves down, so the start bit settles in bit 0
    always_ff @(posedge Clk) begin
        if (sample) begin
            shreg <= {rxd, shreg[NUM_BITS-1:1]};
        end
    end

    assign data_bits  = shreg[DATA_BITS:1];
    assign parity_bit = shreg[PAR_POS];
    assign stop_bits  = shreg[NUM_BITS-1 -: STOP_BITS];

    // Short frames leave the upper data bits at zero
    always_comb begin
        data_ext                  = '0;
        data_ext[DATA_BITS-1:0] = data_bits;
    end

    // The flags are captured in the check state and held through delivery
    always_ff @(posedge Clk) begin
        if (state == ST_CHECK) begin
            char_q.data <= data_ext;
            char_q.brk  <= (shreg == '0);               // Line held low for the whole frame
            char_q.par  <= (^data_bits) ^ parity_bit;   // Even parity expects a zero here
            char_q.frm  <= (stop_bits != '1);
        end
    end

    assign push_char = char_q;

    // A frame that finds the buffer full is dropped and reported as overrun
    assign push          = (state == ST_DELIVER) && !full;
    assign overrun_pulse = (state == ST_DELIVER) && full;

    // Ready to send only when idle and a slot is free
    assign rts = (state == ST_IDLE) && !full;

endmodule

// ==== hw/uart_rx_pkg.sv ====
package uart_rx_pkg;

    // Narrower frames are zero-extended to this many data bits
    localparam int MAX_DATA_BITS = 8;

    // Register addresses seen on the 2-bit Wishbone address
    localparam logic [1:0] ADR_DATA   = 2'd0;  // Pops one character from the buffer
    localparam logic [1:0] ADR_STATUS = 2'd1;  // Buffer state and sticky overrun

    // Bit positions inside the status register
    localparam int STAT_NOT_EMPTY = 0;
    localparam int STAT_FULL      = 1;
    localparam int STAT_OVERRUN   = 2;

    // One received character with its error flags
    // The first member is the MSB, so the flags land in bits 10..8 of the data register
    typedef struct packed {
        logic                     frm;   // Some stop bit was sampled low
        logic                     par;   // Parity bit differs from the XOR of the data bits
        logic                     brk;   // Every bit of the frame was low
        logic [MAX_DATA_BITS-1:0] data;  // Data bits, first bit on the line in bit 0
    } rx_char_t;

    // Wishbone classic request from the bus master
    typedef struct packed {
        logic        cyc;    // Bus cycle in progress
        logic        stb;    // Strobe held until ack
        logic        we;     // Write when high
        logic [1:0]  adr;    // Register address
        logic [15:0] dat_w;  // Write data that this slave ignores
    } wb_req_t;

    // Wishbone classic response from the slave
    typedef struct packed {
        logic        ack;    // One clock wide
        logic [15:0] dat_r;  // Valid while ack is high
    } wb_rsp_t;

endpackage

// ==== hw/uart_rx_top.sv ====
`timescale 1ns/1ps

module uart_rx_top #(
    parameter int DATA_BITS  = 8,   // 5 to 8
    parameter int STOP_BITS  = 2,   // 1 or 2
    parameter int CLK_DIV    = 2,   // Clocks per oversample tick
    parameter int FIFO_DEPTH = 8    // Power of two
) (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 rxd,
    output logic                 rts,
    input  uart_rx_pkg::wb_req_t wb_req,
    output uart_rx_pkg::wb_rsp_t wb_rsp
);

    // Receiver to buffer
    logic                  push;
    uart_rx_pkg::rx_char_t push_char;
    logic                  overrun_pulse;

    // Buffer to bus port
    uart_rx_pkg::rx_char_t head;
    logic                  empty;
    logic                  full;
    logic                  pop;

    // Serial line in, one character per completed frame out
    uart_rx #(
        .DATA_BITS (DATA_BITS),
        .STOP_BITS (STOP_BITS),
        .CLK_DIV   (CLK_DIV)
    ) i_uart_rx (
        .Clk           (Clk),
        .reset         (reset),
        .rxd           (rxd),
        .full          (full),
        .rts           (rts),
        .push          (push),
        .push_char     (push_char),
        .overrun_pulse (overrun_pulse)
    );

    rx_fifo #(
        .payload_t (uart_rx_pkg::rx_char_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_rx_fifo (
        .Clk       (Clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_char),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    // Processor side
    wb_rx_port i_wb_rx_port (
        .Clk           (Clk),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .head          (head),
        .empty         (empty),
        .full          (full),
        .overrun_pulse (overrun_pulse),
        .pop           (pop)
    );

endmodule

// ==== hw/wb_rx_port.sv ====
`timescale 1ns/1ps

module wb_rx_port (
    input  logic                  Clk,
    input  logic                  reset,
    input  uart_rx_pkg::wb_req_t  wb_req,
    output uart_rx_pkg::wb_rsp_t  wb_rsp,
    input  uart_rx_pkg::rx_char_t head,
    input  logic                  empty,
    input  logic                  full,
    input  logic                  overrun_pulse,
    output logic                  pop
);

    logic        ack_q;
    logic        done;      // Current strobe has been answered
    logic        overrun;   // Sticky until a status write
    logic [15:0] dat_q;     // Read data presented with ack
    logic [15:0] rd_mux;

    logic access;
    logic data_rd;
    logic status_wr;

    // A strobe is taken once, then ignored until the master drops it
    assign access = wb_req.cyc && wb_req.stb && !done;

    assign data_rd   = access && !wb_req.we && (wb_req.adr == uart_rx_pkg::ADR_DATA);
    assign status_wr = access && wb_req.we && (wb_req.adr == uart_rx_pkg::ADR_STATUS);

    // Register map for reads
    always_comb begin
        rd_mux = '0;
        if (!wb_req.we) begin
            case (wb_req.adr)
                uart_rx_pkg::ADR_DATA: begin
                    // Empty buffer reads as zero
                    if (!empty) begin
                        rd_mux[$bits(uart_rx_pkg::rx_char_t)-1:0] = head;
                    end
                end
                uart_rx_pkg::ADR_STATUS: begin
                    rd_mux[uart_rx_pkg::STAT_NOT_EMPTY] = !empty;
                    rd_mux[uart_rx_pkg::STAT_FULL]      = full;
                    rd_mux[uart_rx_pkg::STAT_OVERRUN]   = overrun;
                end
                default: ;  // Unused addresses read zero
            endcase
        end
    end

    // Handshake and overrun state
    always_ff @(posedge Clk) begin
        if (reset) begin
            ack_q   <= 1'b0;
            done    <= 1'b0;
            pop     <= 1'b0;
            overrun <= 1'b0;
        end else begin
            ack_q <= access;               // One clock after the strobe is seen
            pop   <= data_rd && !empty;    // Pop lines up with the ack of the data read

            if (access) begin
                done <= 1'b1;
            end else if (!(wb_req.cyc && wb_req.stb)) begin
                done <= 1'b0;              // The next access may start once the strobe is gone
            end

            // A new overrun in the clearing clock keeps the flag set
            if (overrun_pulse) begin
                overrun <= 1'b1;
            end else if (status_wr) begin
                overrun <= 1'b0;
            end
        end
    end

    // Read data is captured with the strobe and stays valid while ack is high
    always_ff @(posedge Clk) begin
        if (access) begin
            dat_q <= rd_mux;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_uart_rx -o tb_uart_rx -f files.f &&
./obj_dir/tb_uart_rx +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== sim/tb_uart_rx.sv ====
`timescale 1ns/1ps

module tb_uart_rx;

    localparam int     CLK_NS     = 40;
    localparam int     BIT_CLKS   = 32;  // 16 ticks of 2 clocks each
    localparam int     FRAME_BITS = 12;  // Start, 8 data, parity, 2 stop
    localparam int     NUM_FRAMES = 20;
    localparam longint TIMEOUT_NS = 2 * NUM_FRAMES * FRAME_BITS * BIT_CLKS * CLK_NS + 20000;

    typedef struct packed {
        logic [7:0] data;
        logic       bad_par;   // Parity bit inverted
        logic       bad_stop;  // First stop bit sent as zero
        logic       brk;       // Whole frame held low
        logic [3:0] burst;     // Number of frames sent before reading on a group's first entry
    } frame_t;

    frame_t frames [NUM_FRAMES];

    logic                 Clk;
    logic                 reset;
    logic                 rxd;
    logic                 rts;
    uart_rx_pkg::wb_req_t wb_req;
    uart_rx_pkg::wb_rsp_t wb_rsp;
    logic                 frame_valid;
    frame_t               frame_sent;   // Entry handed to the scoreboard
    int                   sb_errors;
    int                   ack_count;
    int                   tb_errors = 0;
    int                   access_count = 0;
    logic [31:0]          lcg_state;

    uart_rx_top #(.DATA_BITS(8), .STOP_BITS(2), .CLK_DIV(2), .FIFO_DEPTH(8)) i_dut (
        .Clk(Clk), .reset(reset), .rxd(rxd), .rts(rts), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    uart_rx_scoreboard #(.DEPTH(8)) i_scoreboard (
        .Clk(Clk), .reset(reset), .rxd(rxd), .rts(rts), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .frame_valid(frame_valid), .frame_data(frame_sent.data),
        .frame_bad_par(frame_sent.bad_par), .frame_bad_stop(frame_sent.bad_stop),
        .frame_brk(frame_sent.brk), .error_count(sb_errors), .ack_count(ack_count)
    );

    bind wb_rx_port uart_rx_checker i_checker (
        .Clk(Clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .empty(empty), .full(full), .pop(pop)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_NS / 2) Clk = ~Clk;
    end

    // Filler bytes from a plain 32-bit LCG
    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Serial frame sent LSB first with the last stop bit cut short once it has been sampled
    task automatic send_frame(input frame_t f);
        logic [FRAME_BITS-1:0] bits;
        int                    k;
        bits = {1'b1, !f.bad_stop, (^f.data) ^ f.bad_par, f.data, 1'b0};
        if (f.brk) bits = '0;
        for (k = 0; k < FRAME_BITS - 1; k++) begin
            rxd = bits[k];
            repeat (BIT_CLKS) @(posedge Clk);
            #5;
        end
        rxd = bits[FRAME_BITS-1];
        repeat (BIT_CLKS / 2 + 2) @(posedge Clk);  // Centre sample lies inside this window
        #5 rxd = 1'b1;                              // Line idle before the receiver looks again
        repeat (BIT_CLKS / 2 - 2) @(posedge Clk);
        #5;
    endtask

    task automatic notify_scoreboard(input frame_t f);
        frame_sent  = f;
        frame_valid = 1'b1;
        @(posedge Clk);
        #5 frame_valid = 1'b0;
    endtask

    // Give rts up to two bit times before sending anyway
    task automatic wait_line_ready();
        int n;
        n = 0;
        while (!rts && n < 2 * BIT_CLKS) begin
            @(posedge Clk);
            #5;
            n++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int n;
        @(posedge Clk);  // Leaves stb low for at least one clock
        #5;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        access_count++;
        n = 0;
        do begin
            @(posedge Clk);
            #5;
            n++;
        end while (!wb_rsp.ack && n < 8);
        rdata = wb_rsp.dat_r;
        if (!wb_rsp.ack) begin
            tb_errors++;
            $display("No acknowledge for the access to address %0d", adr);
        end
        @(posedge Clk);  // Strobe stays up through the clock that takes the ack
        #5 wb_req = '0;
    endtask

    task automatic poll_not_empty();
        logic [15:0] status;
        int          n;
        n = 0;
        status = '0;
        while (!status[uart_rx_pkg::STAT_NOT_EMPTY] && n < 50) begin
            bus_access(1'b0, uart_rx_pkg::ADR_STATUS, 16'h0000, status);
            n++;
        end
        if (!status[uart_rx_pkg::STAT_NOT_EMPTY]) begin
            tb_errors++;
            $display("Status never showed a received character");
        end
    endtask

    task automatic set_frame(input int idx, input logic [7:0] data, input logic bad_par,
                             input logic bad_stop, input logic brk, input logic [3:0] burst);
        frames[idx] = '{data: data, bad_par: bad_par, bad_stop: bad_stop, brk: brk, burst: burst};
    endtask

    task automatic build_table();
        int i;
        set_frame(0, 8'h55, 1'b0, 1'b0, 1'b0, 4'd1);  // Clean frames read one at a time
        set_frame(1, lcg_next(), 1'b0, 1'b0, 1'b0, 4'd1);
        set_frame(2, lcg_next(), 1'b0, 1'b0, 1'b0, 4'd1);
        set_frame(3, 8'hA3, 1'b1, 1'b0, 1'b0, 4'd1);  // Parity error only
        set_frame(4, 8'h3C, 1'b0, 1'b1, 1'b0, 4'd1);  // Framing error only
        set_frame(5, 8'h00, 1'b0, 1'b0, 1'b1, 4'd1);  // Break
        for (i = 6; i < NUM_FRAMES; i++) begin
            // Five buffered frames, then nine that overflow the FIFO by one
            set_frame(i, lcg_next(), 1'b0, 1'b0, 1'b0, (i == 6) ? 4'd5 : (i == 11) ? 4'd9 : 4'd0);
        end
    endtask

    initial begin
        int          i;
        int          j;
        int          burst;
        logic [15:0] rd;
        reset       = 1'b1;
        rxd         = 1'b1;
        wb_req      = '0;
        frame_valid = 1'b0;
        frame_sent  = '0;
        lcg_state   = 32'd17862;
        build_table();
        repeat (8) @(posedge Clk);
        #5 reset = 1'b0;
        i = 0;
        while (i < NUM_FRAMES) begin
            burst = int'(frames[i].burst);
            for (j = 0; j < burst; j++) begin
                wait_line_ready();
                send_frame(frames[i + j]);
                notify_scoreboard(frames[i + j]);
            end
            poll_not_empty();  // Also shows full and overrun after the big group
            for (j = 0; j < burst; j++) begin
                bus_access(1'b0, uart_rx_pkg::ADR_DATA, 16'h0000, rd);
            end
            bus_access(1'b0, uart_rx_pkg::ADR_STATUS, 16'h0000, rd);  // Drained
            bus_access(1'b0, uart_rx_pkg::ADR_DATA, 16'h0000, rd);    // Empty reads zero
            bus_access(1'b1, uart_rx_pkg::ADR_STATUS, 16'h0000, rd);  // Clears overrun
            bus_access(1'b0, uart_rx_pkg::ADR_STATUS, 16'h0000, rd);
            i += burst;
        end
        bus_access(1'b0, 2'd3, 16'h0000, rd);  // Unmapped address reads zero
        repeat (4) @(posedge Clk);
        if (ack_count != access_count) begin
            tb_errors++;
            $display("Scoreboard saw %0d acks for %0d bus accesses", ack_count, access_count);
        end
        $display("Errors: scoreboard %0d, testbench %0d, assertions %0d",
                 sb_errors, tb_errors, i_dut.i_wb_rx_port.i_checker.fail_count);
        if (sb_errors == 0 && tb_errors == 0 && i_dut.i_wb_rx_port.i_checker.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Twice the serial time of every frame plus slack for the bus traffic
    initial begin
        #(TIMEOUT_NS);
        $display("Timed out after %0d ns before all frames were checked", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim/uart_rx_checker.sv ====
`timescale 1ns/1ps

module uart_rx_checker (
    input logic                 Clk,
    input logic                 reset,
    input uart_rx_pkg::wb_req_t wb_req,
    input uart_rx_pkg::wb_rsp_t wb_rsp,
    input logic                 empty,
    input logic                 full,
    input logic                 pop
);

    int   fail_count = 0;  // Read by the testbench at the end of the run
    logic strobe;

    assign strobe = wb_req.cyc && wb_req.stb;

    // A new strobe is answered on the very next clock
    ack_after_strobe: assert property (@(posedge Clk) disable iff (reset)
        $rose(strobe) |=> wb_rsp.ack)
        else begin
            $error("Strobe was not acknowledged one clock later");
            fail_count++;
        end

    // Ack is a single clock wide, so each access sees exactly one
    ack_one_clock: assert property (@(posedge Clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("Ack stayed high for two clocks in a row");
            fail_count++;
        end

    ack_needs_strobe: assert property (@(posedge Clk) disable iff (reset)
        wb_rsp.ack |-> strobe)
        else begin
            $error("Ack appeared without a strobe");
            fail_count++;
        end

    flags_exclusive: assert property (@(posedge Clk) disable iff (reset)
        !(full && empty))
        else begin
            $error("FIFO reported full and empty at once");
            fail_count++;
        end

    no_pop_empty: assert property (@(posedge Clk) disable iff (reset)
        pop |-> !empty)
        else begin
            $error("Pop issued while the FIFO was empty");
            fail_count++;
        end

endmodule

// ==== sim/uart_rx_scoreboard.sv ====
`timescale 1ns/1ps

module uart_rx_scoreboard #(
    parameter int DEPTH = 8  // Must match the FIFO depth of the DUT
) (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 rxd,
    input  logic                 rts,
    input  uart_rx_pkg::wb_req_t wb_req,
    input  uart_rx_pkg::wb_rsp_t wb_rsp,
    input  logic                 frame_valid,     // One clock per frame put on the line
    input  logic [7:0]           frame_data,
    input  logic                 frame_bad_par,
    input  logic                 frame_bad_stop,
    input  logic                 frame_brk,
    output int                   error_count,
    output int                   ack_count
);

    uart_rx_pkg::rx_char_t model_q [$];  // Characters the DUT should be holding
    uart_rx_pkg::rx_char_t next_char;
    logic                  overrun;      // Model of the sticky flag
    logic [15:0]           expected;
    logic                  rxd_q;        // Line level at the previous clock

    // Character that a frame should produce from its content alone
    function automatic uart_rx_pkg::rx_char_t predict_char(input logic [7:0] data,
            input logic bad_par, input logic bad_stop, input logic brk);
        uart_rx_pkg::rx_char_t c;
        c.data = brk ? 8'h00 : data;
        c.brk  = brk;
        c.par  = brk ? 1'b0 : bad_par;  // An all-zero frame has correct even parity
        c.frm  = brk || bad_stop;        // Break also zeroes the stop bits
        return c;
    endfunction

    always @(posedge Clk) begin
        if (reset) begin
            model_q.delete();
            overrun     = 1'b0;
            rxd_q       = 1'b1;
            error_count = 0;
            ack_count   = 0;
        end else begin
            // Once the line has gone low the receiver is busy and must not ask for more
            if (!rxd_q && rts) begin
                error_count++;
                $display("error at %0t: rts high while a frame was on the line", $time);
            end
            rxd_q = rxd;
            if (frame_valid) begin
                next_char = predict_char(frame_data, frame_bad_par, frame_bad_stop, frame_brk);
                if (model_q.size() < DEPTH) begin
                    model_q.push_back(next_char);
                end else begin
                    overrun = 1'b1;  // A full buffer drops the frame
                end
                // The receiver is idle again, so rts only follows the free space
                if (rts !== (model_q.size() < DEPTH)) begin
                    error_count++;
                    $display("error at %0t: rts is %b with %0d characters buffered",
                             $time, rts, model_q.size());
                end
            end
            if (wb_rsp.ack) begin
                ack_count++;
                expected = 16'h0000;  // Unused addresses and empty data reads
                if (wb_req.we) begin
                    if (wb_req.adr == uart_rx_pkg::ADR_STATUS) overrun = 1'b0;
                end else if (wb_req.adr == uart_rx_pkg::ADR_DATA && model_q.size() != 0) begin
                    expected = 16'(model_q.pop_front());
                end else if (wb_req.adr == uart_rx_pkg::ADR_STATUS) begin
                    expected[2:0] = {overrun, model_q.size() == DEPTH, model_q.size() != 0};
                end
                if (!wb_req.we && wb_rsp.dat_r !== expected) begin
                    error_count++;
                    $display("error at %0t: read of address %0d returned %h, expected %h",
                             $time, wb_req.adr, wb_rsp.dat_r, expected);
                end
            end
        end
    end

endmodule
